// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = coreTb
FILELIST  = list.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf $(OBJDIR)

// ==== list.f ====
logic/mipsPkg.sv
logic/instrDecode.sv
logic/regFile.sv
logic/aluExec.sv
logic/mulDivUnit.sv
logic/mipsExecCore.sv
tb/clockGen.sv
tb/core_checker.sv
tb/coreTb.sv

// ==== logic/aluExec.sv ====
`timescale 1ns/10ps

module aluExec (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         accept,
    input  mipsPkg::aluOpT               op,
    input  logic [mipsPkg::wordW-1:0]    rsData,
    input  logic [mipsPkg::wordW-1:0]    rtData,
    input  logic [mipsPkg::wordW-1:0]    imm,
    input  logic [mipsPkg::regAddrW-1:0] shamt,
    input  logic [mipsPkg::regAddrW-1:0] rd,
    input  logic                         writesReg,
    output logic                         resValid,
    output logic [mipsPkg::regAddrW-1:0] resReg,
    output logic [mipsPkg::wordW-1:0]    resData,
    output logic                         illegal
);

    logic [mipsPkg::wordW-1:0] aluRes;
    logic [mipsPkg::wordW-1:0] cmpB;
    logic                      ltSigned;
    logic                      ltUnsigned;
    logic                      isAluOp;

    // set-less-than compares against rt or the sign-extended immediate
    assign cmpB       = ((op == mipsPkg::opSlt) || (op == mipsPkg::opSltu)) ? rtData : imm;
    assign ltSigned   = $signed(rsData) < $signed(cmpB);
    assign ltUnsigned = rsData < cmpB;

    always_comb begin
        aluRes  = '0;
        isAluOp = 1'b1;
        case (op)
            mipsPkg::opAddiu: aluRes = rsData + imm;
            mipsPkg::opAddu:  aluRes = rsData + rtData;
            mipsPkg::opSubu:  aluRes = rsData - rtData;
            mipsPkg::opAnd:   aluRes = rsData & rtData;
            mipsPkg::opAndi:  aluRes = rsData & imm;
            mipsPkg::opOr:    aluRes = rsData | rtData;
            mipsPkg::opOri:   aluRes = rsData | imm;
            mipsPkg::opXor:   aluRes = rsData ^ rtData;
            mipsPkg::opXori:  aluRes = rsData ^ imm;
            mipsPkg::opSll:   aluRes = rtData << shamt;
            mipsPkg::opSrl:   aluRes = rtData >> shamt;
            mipsPkg::opSra:   aluRes = $signed(rtData) >>> shamt;
            // variable shifts only look at rs[4:0]
            mipsPkg::opSllv:  aluRes = rtData << rsData[4:0];
            mipsPkg::opSrlv:  aluRes = rtData >> rsData[4:0];
            mipsPkg::opSrav:  aluRes = $signed(rtData) >>> rsData[4:0];
            mipsPkg::opSlt,
            mipsPkg::opSlti:  aluRes = {{(mipsPkg::wordW-1){1'b0}}, ltSigned};
            mipsPkg::opSltu,
            mipsPkg::opSltiu: aluRes = {{(mipsPkg::wordW-1){1'b0}}, ltUnsigned};
            default:          isAluOp = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resValid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            resValid <= accept && isAluOp && writesReg;
            illegal  <= accept && (op == mipsPkg::opIllegal);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resReg  <= rd;
            resData <= aluRes;
        end
    end

endmodule

// ==== logic/instrDecode.sv ====
`timescale 1ns/10ps

module instrDecode (
    input  logic [mipsPkg::wordW-1:0]    instr,
    output mipsPkg::aluOpT               op,
    output logic [mipsPkg::regAddrW-1:0] rs,
    output logic [mipsPkg::regAddrW-1:0] rt,
    output logic [mipsPkg::regAddrW-1:0] rd,
    output logic [mipsPkg::regAddrW-1:0] shamt,
    output logic [mipsPkg::wordW-1:0]    imm,
    output logic                         writesReg
);

    logic [5:0]                   opcode;
    logic [5:0]                   funct;
    logic [mipsPkg::regAddrW-1:0] rdField;
    logic                         isRType;
    logic                         zeroExt;
    logic                         noWrite;

    // instruction fields
    assign opcode  = instr[31:26];
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign rdField = instr[15:11];
    assign shamt   = instr[10:6];
    assign funct   = instr[5:0];
    assign isRType = (opcode == mipsPkg::opcSpecial);

    always_comb begin
        op = mipsPkg::opIllegal;
        if (instr == '0) begin
            // canonical nop
            op = mipsPkg::opNone;
        end else if (isRType) begin
            case (funct)
                mipsPkg::fnSll:   op = mipsPkg::opSll;
                mipsPkg::fnSrl:   op = mipsPkg::opSrl;
                mipsPkg::fnSra:   op = mipsPkg::opSra;
                mipsPkg::fnSllv:  op = mipsPkg::opSllv;
                mipsPkg::fnSrlv:  op = mipsPkg::opSrlv;
                mipsPkg::fnSrav:  op = mipsPkg::opSrav;
                mipsPkg::fnMfhi:  op = mipsPkg::opMfhi;
                mipsPkg::fnMthi:  op = mipsPkg::opMthi;
                mipsPkg::fnMflo:  op = mipsPkg::opMflo;
                mipsPkg::fnMtlo:  op = mipsPkg::opMtlo;
                mipsPkg::fnMult:  op = mipsPkg::opMult;
                mipsPkg::fnMultu: op = mipsPkg::opMultu;
                mipsPkg::fnDiv:   op = mipsPkg::opDiv;
                mipsPkg::fnDivu:  op = mipsPkg::opDivu;
                mipsPkg::fnAddu:  op = mipsPkg::opAddu;
                mipsPkg::fnSubu:  op = mipsPkg::opSubu;
                mipsPkg::fnAnd:   op = mipsPkg::opAnd;
                mipsPkg::fnOr:    op = mipsPkg::opOr;
                mipsPkg::fnXor:   op = mipsPkg::opXor;
                mipsPkg::fnSlt:   op = mipsPkg::opSlt;
                mipsPkg::fnSltu:  op = mipsPkg::opSltu;
                default:          op = mipsPkg::opIllegal;
            endcase
        end else begin
            case (opcode)
                mipsPkg::opcAddiu: op = mipsPkg::opAddiu;
                mipsPkg::opcSlti:  op = mipsPkg::opSlti;
                mipsPkg::opcSltiu: op = mipsPkg::opSltiu;
                mipsPkg::opcAndi:  op = mipsPkg::opAndi;
                mipsPkg::opcOri:   op = mipsPkg::opOri;
                mipsPkg::opcXori:  op = mipsPkg::opXori;
                default:           op = mipsPkg::opIllegal;
            endcase
        end
    end

    // logical immediates are zero-extended, the rest sign-extended
    assign zeroExt = (op == mipsPkg::opAndi) || (op == mipsPkg::opOri) || (op == mipsPkg::opXori);
    assign imm     = zeroExt ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign rd      = isRType ? rdField : rt;

    // ops that only touch hi/lo or nothing at all
    always_comb begin
        case (op)
            mipsPkg::opNone, mipsPkg::opIllegal,
            mipsPkg::opMult, mipsPkg::opMultu,
            mipsPkg::opDiv, mipsPkg::opDivu,
            mipsPkg::opMthi, mipsPkg::opMtlo: noWrite = 1'b1;
            default:                           noWrite = 1'b0;
        endcase
    end

    assign writesReg = !noWrite && (rd != '0);

endmodule

// ==== logic/mipsExecCore.sv ====
`timescale 1ns/10ps

module mipsExecCore (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         instrValid,
    input  logic [mipsPkg::wordW-1:0]    instr,
    output logic                         busy,
    output logic                         wbValid,
    output logic [mipsPkg::regAddrW-1:0] wbReg,
    output logic [mipsPkg::wordW-1:0]    wbData,
    output logic                         illegal
);

    mipsPkg::aluOpT               op;
    logic [mipsPkg::regAddrW-1:0] rs;
    logic [mipsPkg::regAddrW-1:0] rt;
    logic [mipsPkg::regAddrW-1:0] rd;
    logic [mipsPkg::regAddrW-1:0] shamt;
    logic [mipsPkg::wordW-1:0]    imm;
    logic                         writesReg;
    logic [mipsPkg::wordW-1:0]    rsData;
    logic [mipsPkg::wordW-1:0]    rtData;
    logic                         accept;
    logic                         aluValid;
    logic [mipsPkg::regAddrW-1:0] aluReg;
    logic [mipsPkg::wordW-1:0]    aluData;
    logic                         mdValid;
    logic [mipsPkg::regAddrW-1:0] mdReg;
    logic [mipsPkg::wordW-1:0]    mdData;

    // words arriving while the divider runs are dropped
    assign accept = instrValid && !busy;

    instrDecode u_instrDecode (
        .instr(instr), .op(op), .rs(rs), .rt(rt), .rd(rd),
        .shamt(shamt), .imm(imm), .writesReg(writesReg)
    );

    regFile u_regFile (
        .clk(clk), .arstN(arstN), .rs(rs), .rt(rt), .rsData(rsData), .rtData(rtData),
        .wrEn(wbValid), .wrReg(wbReg), .wrData(wbData)
    );

    aluExec u_aluExec (
        .clk(clk), .arstN(arstN), .accept(accept), .op(op),
        .rsData(rsData), .rtData(rtData), .imm(imm), .shamt(shamt),
        .rd(rd), .writesReg(writesReg), .resValid(aluValid), .resReg(aluReg),
        .resData(aluData), .illegal(illegal)
    );

    mulDivUnit u_mulDivUnit (
        .clk(clk), .arstN(arstN), .accept(accept), .op(op),
        .rsData(rsData), .rtData(rtData), .rd(rd), .writesReg(writesReg),
        .busy(busy), .resValid(mdValid), .resReg(mdReg), .resData(mdData)
    );

    // at most one unit has a result in a given cycle
    assign wbValid = aluValid || mdValid;
    assign wbReg   = (aluValid ? aluReg : '0) | (mdValid ? mdReg : '0);
    assign wbData  = (aluValid ? aluData : '0) | (mdValid ? mdData : '0);

endmodule

// ==== logic/mipsPkg.sv ====
package mipsPkg;

    // datapath widths
    localparam int wordW    = 32;
    localparam int regAddrW = 5;
    localparam int divSteps = 32;

    // primary opcodes
    localparam logic [5:0] opcSpecial = 6'h00;
    localparam logic [5:0] opcAddiu   = 6'h09;
    localparam logic [5:0] opcSlti    = 6'h0A;
    localparam logic [5:0] opcSltiu   = 6'h0B;
    localparam logic [5:0] opcAndi    = 6'h0C;
    localparam logic [5:0] opcOri     = 6'h0D;
    localparam logic [5:0] opcXori    = 6'h0E;

    // funct field of the special opcode
    localparam logic [5:0] fnSll   = 6'h00;
    localparam logic [5:0] fnSrl   = 6'h02;
    localparam logic [5:0] fnSra   = 6'h03;
    localparam logic [5:0] fnSllv  = 6'h04;
    localparam logic [5:0] fnSrlv  = 6'h06;
    localparam logic [5:0] fnSrav  = 6'h07;
    localparam logic [5:0] fnMfhi  = 6'h10;
    localparam logic [5:0] fnMthi  = 6'h11;
    localparam logic [5:0] fnMflo  = 6'h12;
    localparam logic [5:0] fnMtlo  = 6'h13;
    localparam logic [5:0] fnMult  = 6'h18;
    localparam logic [5:0] fnMultu = 6'h19;
    localparam logic [5:0] fnDiv   = 6'h1A;
    localparam logic [5:0] fnDivu  = 6'h1B;
    localparam logic [5:0] fnAddu  = 6'h21;
    localparam logic [5:0] fnSubu  = 6'h23;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnXor   = 6'h26;
    localparam logic [5:0] fnSlt   = 6'h2A;
    localparam logic [5:0] fnSltu  = 6'h2B;

    typedef enum logic [5:0] {
        opNone, opIllegal,
        opAddiu, opAddu, opSubu,
        opAnd, opAndi, opOr, opOri, opXor, opXori,
        opSll, opSllv, opSrl, opSrlv, opSra, opSrav,
        opSlt, opSlti, opSltu, opSltiu,
        opMult, opMultu, opDiv, opDivu,
        opMthi, opMtlo, opMfhi, opMflo
    } aluOpT;

    typedef enum logic [1:0] {divIdle, divRun, divFix} divStateT;

endpackage

// ==== logic/mulDivUnit.sv ====
`timescale 1ns/10ps

module mulDivUnit (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         accept,
    input  mipsPkg::aluOpT               op,
    input  logic [mipsPkg::wordW-1:0]    rsData,
    input  logic [mipsPkg::wordW-1:0]    rtData,
    input  logic [mipsPkg::regAddrW-1:0] rd,
    input  logic                         writesReg,
    output logic                         busy,
    output logic                         resValid,
    output logic [mipsPkg::regAddrW-1:0] resReg,
    output logic [mipsPkg::wordW-1:0]    resData
);

    mipsPkg::divStateT                     state;
    logic [$clog2(mipsPkg::divSteps)-1:0]  stepCnt;
    logic [mipsPkg::wordW-1:0]             hi;
    logic [mipsPkg::wordW-1:0]             lo;
    logic signed [2*mipsPkg::wordW-1:0]    sProd;
    logic [2*mipsPkg::wordW-1:0]           uProd;
    logic [mipsPkg::wordW-1:0]             quo;
    logic [mipsPkg::wordW-1:0]             rem;
    logic [mipsPkg::wordW-1:0]             dvsr;
    logic                                  negQ;
    logic                                  negR;
    logic [mipsPkg::wordW:0]               remShift;
    logic [mipsPkg::wordW:0]               diff;
    logic                                  startDiv;
    logic                                  isSigned;

    assign sProd    = $signed(rsData) * $signed(rtData);
    assign uProd    = rsData * rtData;
    assign startDiv = accept && ((op == mipsPkg::opDiv) || (op == mipsPkg::opDivu));
    assign isSigned = (op == mipsPkg::opDiv);
    assign busy     = (state != mipsPkg::divIdle);

    // one restoring step, bring down the next dividend bit
    assign remShift = {rem, quo[mipsPkg::wordW-1]};
    assign diff     = remShift - {1'b0, dvsr};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= mipsPkg::divIdle;
            stepCnt  <= '0;
            hi       <= '0;
            lo       <= '0;
            resValid <= 1'b0;
        end else begin
            resValid <= accept && writesReg &&
                        ((op == mipsPkg::opMfhi) || (op == mipsPkg::opMflo));
            case (state)
                mipsPkg::divIdle: begin
                    stepCnt <= '0;
                    if (startDiv) begin
                        state <= mipsPkg::divRun;
                    end else if (accept && (op == mipsPkg::opMult)) begin
                        {hi, lo} <= sProd;
                    end else if (accept && (op == mipsPkg::opMultu)) begin
                        {hi, lo} <= uProd;
                    end else if (accept && (op == mipsPkg::opMthi)) begin
                        hi <= rsData;
                    end else if (accept && (op == mipsPkg::opMtlo)) begin
                        lo <= rsData;
                    end
                end
                mipsPkg::divRun: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (stepCnt == mipsPkg::divSteps - 1) begin
                        state <= mipsPkg::divFix;
                    end
                end
                default: begin
                    // signs go back on the magnitudes
                    lo    <= negQ ? -quo : quo;
                    hi    <= negR ? -rem : rem;
                    state <= mipsPkg::divIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (startDiv) begin
            negQ <= isSigned && (rsData[mipsPkg::wordW-1] ^ rtData[mipsPkg::wordW-1]);
            negR <= isSigned && rsData[mipsPkg::wordW-1];
            quo  <= (isSigned && rsData[mipsPkg::wordW-1]) ? -rsData : rsData;
            dvsr <= (isSigned && rtData[mipsPkg::wordW-1]) ? -rtData : rtData;
            rem  <= '0;
        end else if (state == mipsPkg::divRun) begin
            if (!diff[mipsPkg::wordW]) begin
                rem <= diff[mipsPkg::wordW-1:0];
                quo <= {quo[mipsPkg::wordW-2:0], 1'b1};
            end else begin
                rem <= remShift[mipsPkg::wordW-1:0];
                quo <= {quo[mipsPkg::wordW-2:0], 1'b0};
            end
        end
        if (accept) begin
            resReg  <= rd;
            resData <= (op == mipsPkg::opMfhi) ? hi : lo;
        end
    end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/10ps

module regFile (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic [mipsPkg::regAddrW-1:0] rs,
    input  logic [mipsPkg::regAddrW-1:0] rt,
    output logic [mipsPkg::wordW-1:0]    rsData,
    output logic [mipsPkg::wordW-1:0]    rtData,
    input  logic                         wrEn,
    input  logic [mipsPkg::regAddrW-1:0] wrReg,
    input  logic [mipsPkg::wordW-1:0]    wrData
);

    logic [mipsPkg::wordW-1:0] regs [32];
    logic                      wrLive;

    // register zero is never written
    assign wrLive = wrEn && (wrReg != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrReg] <= wrData;
        end
    end

    // read ports see a write landing at the end of this cycle
    always_comb begin
        if (rs == '0) begin
            rsData = '0;
        end else if (wrLive && (wrReg == rs)) begin
            rsData = wrData;
        end else begin
            rsData = regs[rs];
        end
    end

    always_comb begin
        if (rt == '0) begin
            rtData = '0;
        end else if (wrLive && (wrReg == rt)) begin
            rtData = wrData;
        end else begin
            rtData = regs[rt];
        end
    end

endmodule

// ==== tb/clockGen.sv ====
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic arstN
);

    localparam int halfPeriod = 50;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // reset held low for three rising edges
    initial begin
        arstN = 1'b0;
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

// ==== tb/coreTb.sv ====
`timescale 1ns/10ps

module coreTb;

    typedef struct packed {
        logic [mipsPkg::wordW-1:0]    word;
        logic                         expWb;
        logic [mipsPkg::regAddrW-1:0] expReg;
        logic [mipsPkg::wordW-1:0]    expData;
        logic                         expIll;
        logic                         waitBusy;
    } stepT;

    logic                         clk;
    logic                         arstN;
    logic                         instrValid;
    logic [mipsPkg::wordW-1:0]    instr;
    logic                         busy;
    logic                         wbValid;
    logic [mipsPkg::regAddrW-1:0] wbReg;
    logic [mipsPkg::wordW-1:0]    wbData;
    logic                         illegal;

    stepT steps[$];
    int   numDivs = 0;
    int   mismatchCnt = 0;
    int   otherCnt = 0;
    int   cycleCnt = 0;
    int   cycleLimit = 0;
    logic tableReady = 1'b0;

    clockGen u_clockGen (.clk(clk), .arstN(arstN));

    mipsExecCore u_mipsExecCore (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr),
        .busy(busy), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .illegal(illegal)
    );

    function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd,
                                            input logic [4:0] sh);
        return {mipsPkg::opcSpecial, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] opc, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    // hi in the upper half and lo in the lower half
    function automatic logic [63:0] divModel(input logic [31:0] a, input logic [31:0] b,
                                             input logic sgn);
        logic        negA;
        logic        negB;
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] r;
        negA = sgn && a[31];
        negB = sgn && b[31];
        ma = negA ? -a : a;
        mb = negB ? -b : b;
        if (mb == 32'd0) begin
            q = '1;
            r = ma;
        end else begin
            q = ma / mb;
            r = ma % mb;
        end
        // quotient truncates toward zero and the remainder follows the dividend
        if (negA ^ negB) q = -q;
        if (negA) r = -r;
        return {r, q};
    endfunction

    task automatic addStep(input logic [31:0] word, input logic wb, input logic [4:0] r,
                           input logic [31:0] d, input logic ill, input logic wt);
        stepT s;
        s.word = word;
        s.expWb = wb;
        s.expReg = r;
        s.expData = d;
        s.expIll = ill;
        s.waitBusy = wt;
        steps.push_back(s);
        if (wt) numDivs++;
    endtask

    // a full word takes addiu, sll and ori as there is no lui
    task automatic loadWord(input logic [4:0] r, input logic [31:0] v);
        addStep(encodeI(mipsPkg::opcAddiu, 5'd0, r, v[31:16]), 1'b1, r,
                {{16{v[31]}}, v[31:16]}, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnSll, 5'd0, r, r, 5'd16), 1'b1, r, {v[31:16], 16'h0000},
                1'b0, 1'b0);
        addStep(encodeI(mipsPkg::opcOri, r, r, v[15:0]), 1'b1, r, v, 1'b0, 1'b0);
    endtask

    task automatic divCase(input logic [4:0] rsR, input logic [4:0] rtR, input logic [31:0] a,
                           input logic [31:0] b, input logic sgn);
        logic [63:0] hl;
        hl = divModel(a, b, sgn);
        addStep(encodeR(sgn ? mipsPkg::fnDiv : mipsPkg::fnDivu, rsR, rtR, 5'd0, 5'd0),
                1'b0, 5'd0, 32'd0, 1'b0, 1'b1);
        addStep(encodeR(mipsPkg::fnMfhi, 5'd0, 5'd0, 5'd29, 5'd0), 1'b1, 5'd29, hl[63:32],
                1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnMflo, 5'd0, 5'd0, 5'd30, 5'd0), 1'b1, 5'd30, hl[31:0],
                1'b0, 1'b0);
    endtask

    task automatic buildTable();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [63:0] p;
        a = $urandom | 32'h8000_0000;
        b = $urandom & 32'h7FFF_FFFF;
        c = $urandom | 32'h8000_0000;
        // sign- versus zero-extended immediates
        addStep(encodeI(mipsPkg::opcAddiu, 5'd0, 5'd1, 16'hFFFB), 1'b1, 5'd1, 32'hFFFF_FFFB,
                1'b0, 1'b0);
        addStep(encodeI(mipsPkg::opcOri, 5'd0, 5'd2, 16'h8001), 1'b1, 5'd2, 32'h0000_8001,
                1'b0, 1'b0);
        addStep(encodeI(mipsPkg::opcAndi, 5'd1, 5'd3, 16'h8F0F), 1'b1, 5'd3, 32'h0000_8F0B,
                1'b0, 1'b0);
        addStep(encodeI(mipsPkg::opcXori, 5'd1, 5'd4, 16'hFFFF), 1'b1, 5'd4, 32'hFFFF_0004,
                1'b0, 1'b0);
        // register ALU ops with a negative and b positive
        loadWord(5'd5, a);
        loadWord(5'd6, b);
        addStep(encodeR(mipsPkg::fnAddu, 5'd5, 5'd6, 5'd7, 5'd0), 1'b1, 5'd7, a + b, 1'b0, 1'b0);
        // reads r7 straight out of writeback
        addStep(encodeR(mipsPkg::fnSubu, 5'd7, 5'd6, 5'd8, 5'd0), 1'b1, 5'd8, a, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnAnd, 5'd5, 5'd6, 5'd9, 5'd0), 1'b1, 5'd9, a & b, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnOr, 5'd5, 5'd6, 5'd10, 5'd0), 1'b1, 5'd10, a | b, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnXor, 5'd5, 5'd6, 5'd11, 5'd0), 1'b1, 5'd11, a ^ b, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnSlt, 5'd5, 5'd6, 5'd12, 5'd0), 1'b1, 5'd12,
                {31'b0, $signed(a) < $signed(b)}, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnSltu, 5'd5, 5'd6, 5'd13, 5'd0), 1'b1, 5'd13,
                {31'b0, a < b}, 1'b0, 1'b0);
        addStep(encodeI(mipsPkg::opcSlti, 5'd6, 5'd14, 16'hFFFF), 1'b1, 5'd14,
                {31'b0, $signed(b) < $signed(32'hFFFF_FFFF)}, 1'b0, 1'b0);
        addStep(encodeI(mipsPkg::opcSltiu, 5'd6, 5'd15, 16'h8000), 1'b1, 5'd15,
                {31'b0, b < 32'hFFFF_8000}, 1'b0, 1'b0);
        // shifts on a negative word
        // r20 holds 37 so variable shifts move by 5
        loadWord(5'd16, c);
        addStep(encodeI(mipsPkg::opcAddiu, 5'd0, 5'd20, 16'd37), 1'b1, 5'd20, 32'd37, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnSll, 5'd0, 5'd16, 5'd17, 5'd4), 1'b1, 5'd17, c << 4, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnSrl, 5'd0, 5'd16, 5'd18, 5'd4), 1'b1, 5'd18, c >> 4, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnSra, 5'd0, 5'd16, 5'd19, 5'd4), 1'b1, 5'd19,
                $signed(c) >>> 4, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnSllv, 5'd20, 5'd16, 5'd21, 5'd0), 1'b1, 5'd21, c << 5,
                1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnSrlv, 5'd20, 5'd16, 5'd22, 5'd0), 1'b1, 5'd22, c >> 5,
                1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnSrav, 5'd20, 5'd16, 5'd23, 5'd0), 1'b1, 5'd23,
                $signed(c) >>> 5, 1'b0, 1'b0);
        // hi/lo moves and products
        p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        addStep(encodeR(mipsPkg::fnMult, 5'd5, 5'd6, 5'd0, 5'd0), 1'b0, 5'd0, 32'd0, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnMfhi, 5'd0, 5'd0, 5'd22, 5'd0), 1'b1, 5'd22, p[63:32],
                1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnMflo, 5'd0, 5'd0, 5'd23, 5'd0), 1'b1, 5'd23, p[31:0],
                1'b0, 1'b0);
        p = {32'b0, a} * {32'b0, b};
        addStep(encodeR(mipsPkg::fnMultu, 5'd5, 5'd6, 5'd0, 5'd0), 1'b0, 5'd0, 32'd0, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnMfhi, 5'd0, 5'd0, 5'd24, 5'd0), 1'b1, 5'd24, p[63:32],
                1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnMflo, 5'd0, 5'd0, 5'd25, 5'd0), 1'b1, 5'd25, p[31:0],
                1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnMthi, 5'd5, 5'd0, 5'd0, 5'd0), 1'b0, 5'd0, 32'd0, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnMfhi, 5'd0, 5'd0, 5'd24, 5'd0), 1'b1, 5'd24, a, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnMtlo, 5'd6, 5'd0, 5'd0, 5'd0), 1'b0, 5'd0, 32'd0, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnMflo, 5'd0, 5'd0, 5'd25, 5'd0), 1'b1, 5'd25, b, 1'b0, 1'b0);
        // divide operands 100, -100, 7 and -7
        addStep(encodeI(mipsPkg::opcAddiu, 5'd0, 5'd24, 16'd100), 1'b1, 5'd24, 32'd100,
                1'b0, 1'b0);
        addStep(encodeI(mipsPkg::opcAddiu, 5'd0, 5'd26, 16'hFF9C), 1'b1, 5'd26, 32'hFFFF_FF9C,
                1'b0, 1'b0);
        addStep(encodeI(mipsPkg::opcAddiu, 5'd0, 5'd27, 16'd7), 1'b1, 5'd27, 32'd7, 1'b0, 1'b0);
        addStep(encodeI(mipsPkg::opcAddiu, 5'd0, 5'd28, 16'hFFF9), 1'b1, 5'd28, 32'hFFFF_FFF9,
                1'b0, 1'b0);
        divCase(5'd24, 5'd27, 32'd100, 32'd7, 1'b1);
        divCase(5'd26, 5'd27, 32'hFFFF_FF9C, 32'd7, 1'b1);
        divCase(5'd24, 5'd28, 32'd100, 32'hFFFF_FFF9, 1'b1);
        divCase(5'd26, 5'd28, 32'hFFFF_FF9C, 32'hFFFF_FFF9, 1'b1);
        divCase(5'd26, 5'd0, 32'hFFFF_FF9C, 32'd0, 1'b1);
        divCase(5'd26, 5'd27, 32'hFFFF_FF9C, 32'd7, 1'b0);
        divCase(5'd24, 5'd0, 32'd100, 32'd0, 1'b0);
        a = $urandom;
        b = $urandom | 32'h0000_0100;
        loadWord(5'd5, a);
        loadWord(5'd6, b);
        divCase(5'd5, 5'd6, a, b, 1'b1);
        // undefined words and then a write to r0 read straight back
        addStep(encodeI(6'h3F, 5'd1, 5'd2, 16'h1234), 1'b0, 5'd0, 32'd0, 1'b1, 1'b0);
        addStep(encodeR(6'h01, 5'd1, 5'd2, 5'd3, 5'd0), 1'b0, 5'd0, 32'd0, 1'b1, 1'b0);
        addStep(encodeI(mipsPkg::opcAddiu, 5'd1, 5'd0, 16'd123), 1'b0, 5'd0, 32'd0, 1'b0, 1'b0);
        addStep(encodeR(mipsPkg::fnOr, 5'd0, 5'd0, 5'd31, 5'd0), 1'b1, 5'd31, 32'd0, 1'b0, 1'b0);
    endtask

    task automatic checkWb(input int idx, input logic expValid,
                           input logic [mipsPkg::regAddrW-1:0] expReg,
                           input logic [mipsPkg::wordW-1:0] expData);
        if (wbValid !== expValid) begin
            mismatchCnt++;
            $display("Mismatch at %0t: step %0d wbValid %b, expected %b",
                     $time, idx, wbValid, expValid);
        end else if (expValid && ((wbReg !== expReg) || (wbData !== expData))) begin
            mismatchCnt++;
            $display("Mismatch at %0t: step %0d wrote r%0d=%h, expected r%0d=%h",
                     $time, idx, wbReg, wbData, expReg, expData);
        end
    endtask

    task automatic checkFlag(input int idx, input logic expIll);
        if (illegal !== expIll) begin
            mismatchCnt++;
            $display("Mismatch at %0t: step %0d illegal %b, expected %b",
                     $time, idx, illegal, expIll);
        end
    endtask

    task automatic checkStep(input int idx);
        checkFlag(idx, steps[idx].expIll);
        checkWb(idx, steps[idx].expWb, steps[idx].expReg, steps[idx].expData);
    endtask

    // results of a step show up one edge after its accept edge
    initial begin
        int pend;
        int assertCnt;
        instrValid = 1'b0;
        instr = '0;
        void'($urandom(49));
        buildTable();
        tableReady = 1'b1;
        pend = -1;
        wait (arstN === 1'b1);
        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clk);
            instrValid <= 1'b1;
            instr <= steps[i].word;
            @(negedge clk);
            if (pend >= 0) checkStep(pend);
            pend = i;
            if (steps[i].waitBusy) begin
                @(posedge clk);
                instrValid <= 1'b0;
                @(negedge clk);
                checkStep(i);
                pend = -1;
                if (busy !== 1'b1) begin
                    otherCnt++;
                    $display("ERROR: busy did not rise after the divide at step %0d", i);
                end
                while (busy) @(negedge clk);
            end
        end
        @(posedge clk);
        instrValid <= 1'b0;
        @(negedge clk);
        if (pend >= 0) checkStep(pend);
        assertCnt = u_mipsExecCore.u_coreChecker.failCnt;
        $display("errors: %0d mismatches, %0d assertion failures, %0d other failures",
                 mismatchCnt, assertCnt, otherCnt);
        if ((mismatchCnt == 0) && (assertCnt == 0) && (otherCnt == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // ten cycles per step plus the divide loops
    initial begin
        wait (tableReady);
        cycleLimit = 10 * steps.size() + mipsPkg::divSteps * numDivs;
        while (cycleCnt < cycleLimit) begin
            @(posedge clk);
            cycleCnt++;
        end
        $display("ERROR: timeout, the run did not finish within %0d cycles", cycleLimit);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== tb/core_checker.sv ====
`timescale 1ns/10ps

module coreChecker (
    input logic clk,
    input logic arstN,
    input logic busy,
    input logic wbValid,
    input logic illegal
);

    logic [7:0] busyLen;
    // number of failed assertions
    int         failCnt = 0;

    // consecutive cycles with busy high
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busyLen <= '0;
        end else if (busy) begin
            busyLen <= busyLen + 8'd1;
        end else begin
            busyLen <= '0;
        end
    end

    wbNotIllegal: assert property (@(posedge clk) disable iff (!arstN) !(wbValid && illegal))
        else begin
            failCnt++;
            $error("wbValid and illegal high in the same cycle");
        end

    wbNotBusy: assert property (@(posedge clk) disable iff (!arstN) !(wbValid && busy))
        else begin
            failCnt++;
            $error("wbValid high while the divider is busy");
        end

    busyLength: assert property (@(posedge clk) disable iff (!arstN)
        $fell(busy) |-> (busyLen == 8'(mipsPkg::divSteps + 1)))
        else begin
            failCnt++;
            $error("busy pulse shorter than the divide length");
        end

    busyBound: assert property (@(posedge clk) disable iff (!arstN)
        busy |-> (busyLen <= 8'(mipsPkg::divSteps)))
        else begin
            failCnt++;
            $error("busy pulse longer than the divide length");
        end

endmodule

bind mipsExecCore coreChecker u_coreChecker (
    .clk(clk), .arstN(arstN), .busy(busy), .wbValid(wbValid), .illegal(illegal)
);
